// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cyclic_buffer_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing

SOURCES := $(shell grep -v '^+' $(FILELIST)) include/cyclic_cfg.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "TEST PASS" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== include/cyclic_cfg.svh ====
`ifndef CYCLIC_CFG_SVH
`define CYCLIC_CFG_SVH

// Memory geometry counted in read words
`define CB_R_DEPTH      16
`define CB_R_DATA_WIDTH 8

`define CB_W_DATA_WIDTH 32  // Four read lanes per write word

// Enabled cycles from read address to memory output
`define CB_LATENCY      3

`endif

// ==== list.f ====
+incdir+include
src/cyclic_pkg.sv
src/bram_sdp.sv
src/absorb_fifo.sv
src/cyclic_bram.sv
src/cyclic_buffer.sv
sim/cyclic_buffer_tb.sv

// ==== sim/cyclic_buffer_tb.sv ====
`include "cyclic_cfg.svh"

module cyclic_buffer_tb;

  import cyclic_pkg::*;

  localparam int n_lat      = `CB_LATENCY;
  localparam int bp_cycles  = 200;
  // Reset, idle, fill, full read, window, write wrap, back-pressure, settle
  localparam int run_cycles = 2 + 8 + 5 + 17 + 62 + 33 + bp_cycles + 4 * n_lat + 10;
  localparam int max_cycles = 2 * run_cycles;

  logic                        clk;
  logic                        arst_n;
  logic                        clken;
  logic                        cfg_load;
  logic [cb_r_addr_w-1:0]      cfg_r_addr_min;
  logic [cb_r_addr_w-1:0]      cfg_r_addr_max;
  logic [cb_w_addr_w-1:0]      cfg_w_addr_max;
  logic                        w_en;
  logic [`CB_W_DATA_WIDTH-1:0] s_data;
  logic                        r_en;
  logic [`CB_R_DATA_WIDTH-1:0] m_data;
  logic                        m_valid;

  // Reference model
  logic [`CB_R_DATA_WIDTH-1:0] model_mem [`CB_R_DEPTH];
  logic [cb_r_addr_w-1:0]      model_rptr;
  logic [cb_r_addr_w-1:0]      model_rmin;
  logic [cb_r_addr_w-1:0]      model_rmax;
  logic [cb_w_addr_w-1:0]      model_wptr;
  logic [cb_w_addr_w-1:0]      model_wmax;
  logic [`CB_R_DATA_WIDTH-1:0] exp_q [$];  // Bytes requested and not yet popped

  logic [15:0] lfsr;
  int          cycles;

  cyclic_buffer uut (
    .clk            (clk),
    .arst_n         (arst_n),
    .clken          (clken),
    .cfg_load       (cfg_load),
    .cfg_r_addr_min (cfg_r_addr_min),
    .cfg_r_addr_max (cfg_r_addr_max),
    .cfg_w_addr_max (cfg_w_addr_max),
    .w_en           (w_en),
    .s_data         (s_data),
    .r_en           (r_en),
    .m_data         (m_data),
    .m_valid        (m_valid)
  );

  always #5 clk = ~clk;

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // x^16 + x^14 + x^13 + x^11 + 1
  endfunction

  function automatic logic rand_bit();
    lfsr = lfsr_step(lfsr);
    return lfsr[0];
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits[i] = rand_bit();
    end
    return bits;
  endfunction

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "Run stopped at cycle %0d", cycles);
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      fail_now($sformatf("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic drive_cycle(input logic ce, input logic wr, input logic [31:0] data,
                             input logic rd);
    @(posedge clk);
    clken    <= ce;
    w_en     <= wr;
    s_data   <= data;
    r_en     <= rd;
    cfg_load <= 1'b0;
  endtask

  task automatic load_cfg(input logic [cb_r_addr_w-1:0] rmin, input logic [cb_r_addr_w-1:0] rmax,
                          input logic [cb_w_addr_w-1:0] wmax);
    @(posedge clk);
    cfg_load       <= 1'b1;
    cfg_r_addr_min <= rmin;
    cfg_r_addr_max <= rmax;
    cfg_w_addr_max <= wmax;
    w_en           <= 1'b0;
    r_en           <= 1'b0;
  endtask

  always @(posedge clk) begin : model_step
    cb_w_word_t                  word;
    logic [`CB_R_DATA_WIDTH-1:0] exp_byte;
    if (!arst_n) begin
      model_rptr <= '0;
      model_wptr <= '0;
      model_rmin <= '0;
      model_rmax <= cb_r_addr_w'(`CB_R_DEPTH - 1);
      model_wmax <= cb_w_addr_w'(cb_w_depth - 1);
      exp_q.delete();
    end else begin
      if (clken && r_en && m_valid) begin
        if (exp_q.size() == 0) begin
          fail_now("DUT popped a byte although no read was outstanding");
        end else begin
          exp_byte = exp_q.pop_front();
          check_value("m_data", 32'(m_data), 32'(exp_byte));
        end
      end
      if (clken && r_en) begin
        exp_q.push_back(model_mem[model_rptr]);  // Sees memory before this edge's write
        model_rptr <= (model_rptr == model_rmax) ? model_rmin : model_rptr + 1'b1;
      end
      if (clken && w_en) begin
        word = s_data;
        for (int k = 0; k < cb_lanes; k++) begin
          model_mem[cb_r_addr_w'(int'(model_wptr) * cb_lanes + k)] <= word.lane[k];
        end
        model_wptr <= (model_wptr == model_wmax) ? '0 : model_wptr + 1'b1;
      end
      if (cfg_load) begin
        model_rmin <= cfg_r_addr_min;
        model_rmax <= cfg_r_addr_max;
        model_wmax <= cfg_w_addr_max;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      fail_now("Timeout: the run did not finish within the cycle limit");
    end
  end

  initial begin : stimulus
    logic [cb_r_addr_w-1:0] lo;
    logic [cb_r_addr_w-1:0] hi;
    logic [cb_r_addr_w-1:0] tmp;
    clk            = 1'b0;
    arst_n         = 1'b0;
    clken          = 1'b1;
    cfg_load       = 1'b0;
    cfg_r_addr_min = '0;
    cfg_r_addr_max = '0;
    cfg_w_addr_max = '0;
    w_en           = 1'b0;
    s_data         = '0;
    r_en           = 1'b0;
    cycles         = 0;
    lfsr           = 16'd21211;
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;

    // Nothing may show before any read is issued
    repeat (8) begin
      @(negedge clk);
      check_value("m_valid", 32'(m_valid), 32'd0);
    end

    // Fill every write word, then replay the whole memory
    repeat (cb_w_depth) drive_cycle(1'b1, 1'b1, rand_bits(32), 1'b0);
    repeat (`CB_R_DEPTH) drive_cycle(1'b1, 1'b0, '0, 1'b1);

    lo = cb_r_addr_w'(rand_bits(cb_r_addr_w));
    hi = cb_r_addr_w'(rand_bits(cb_r_addr_w));
    if (lo > hi) begin
      tmp = lo;
      lo  = hi;
      hi  = tmp;
    end
    load_cfg(lo, hi, cb_w_addr_w'(cb_w_depth - 1));
    repeat (60) drive_cycle(1'b1, 1'b0, '0, 1'b1);

    // Two write slots, the later word wins
    load_cfg('0, cb_r_addr_w'(`CB_R_DEPTH - 1), cb_w_addr_w'(1));
    repeat (6) drive_cycle(1'b1, 1'b1, rand_bits(32), 1'b0);
    repeat (24) drive_cycle(1'b1, 1'b0, '0, 1'b1);

    // Reads stay in the upper half while writes land in the lower half
    load_cfg(cb_r_addr_w'(8), cb_r_addr_w'(`CB_R_DEPTH - 1), cb_w_addr_w'(1));
    repeat (bp_cycles) drive_cycle(rand_bit() | rand_bit(), rand_bit(), rand_bits(32), rand_bit());

    drive_cycle(1'b1, 1'b0, '0, 1'b0);
    while (m_valid !== 1'b1) @(negedge clk);
    repeat (n_lat + 1) @(negedge clk);
    if (exp_q.size() == 0 || exp_q.size() > n_lat) begin
      fail_now($sformatf("Outstanding reads out of range at the end: %0d", exp_q.size()));
    end else begin
      check_value("m_valid", 32'(m_valid), 32'd1);
      check_value("m_data", 32'(m_data), 32'(exp_q[0]));
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

// ==== src/absorb_fifo.sv ====
`include "cyclic_cfg.svh"

module absorb_fifo #(
  parameter int width    = `CB_R_DATA_WIDTH,
  parameter int depth    = `CB_LATENCY,
  localparam int ptr_w   = (depth > 1) ? $clog2(depth) : 1,
  localparam int cnt_w   = $clog2(depth + 1)
)(
  input  logic             clk,
  input  logic             arst_n,
  input  logic             en,
  input  logic             push,
  input  logic [width-1:0] push_data,
  input  logic             pop,
  output logic             valid,
  output logic [width-1:0] head
);

  logic [width-1:0] store [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w:0]   count;  // Top bit makes an overrun past depth visible
  logic             empty;
  logic             take;
  logic             wr;
  logic             rd;

  function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
    return (p == ptr_w'(depth - 1)) ? '0 : ptr_w'(p + 1'b1);
  endfunction

  assign empty = (count == '0);

  // An arriving word is shown at once when nothing is queued
  assign valid = !empty || push;
  assign head  = empty ? push_data : store[rd_ptr];

  assign take = en && pop && valid;
  assign wr   = en && push && !(take && empty);  // Bypassed word is not stored
  assign rd   = take && !empty;

  always_ff @(posedge clk) begin
    if (wr) begin
      store[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (rd) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      if (wr && !rd) begin
        count <= count + 1'b1;
      end else if (rd && !wr) begin
        count <= count - 1'b1;
      end
    end
  end

  // Upstream keeps reads in flight plus queued within depth
  a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n)
    en && push |-> count != {1'b0, cnt_w'(depth)});

  a_count_bound: assert property (@(posedge clk) disable iff (!arst_n)
    count <= {1'b0, cnt_w'(depth)});

endmodule

// ==== src/bram_sdp.sv ====
`include "cyclic_cfg.svh"

module bram_sdp #(
  parameter int r_depth        = `CB_R_DEPTH,
  parameter int r_data_width   = `CB_R_DATA_WIDTH,
  parameter int w_data_width   = `CB_W_DATA_WIDTH,
  parameter int latency        = `CB_LATENCY,
  localparam int lanes         = w_data_width / r_data_width,
  localparam int r_addr_w      = $clog2(r_depth),
  localparam int w_addr_w      = $clog2(r_depth / lanes)
)(
  input  logic                       clk,
  input  logic                       en,
  input  logic                       we,
  input  logic [w_addr_w-1:0]        w_addr,
  input  cyclic_pkg::cb_w_word_t     w_data,
  input  logic [r_addr_w-1:0]        r_addr,
  output logic [r_data_width-1:0]    r_data
);

  // Stored one row per read address
  logic [r_data_width-1:0] mem [r_depth];

  // Read pipe, stage 0 holds the freshly addressed row
  logic [r_data_width-1:0] rd_pipe [latency];

  // Write word spreads over consecutive read rows
  always_ff @(posedge clk) begin
    if (en && we) begin
      for (int k = 0; k < lanes; k++) begin
        mem[r_addr_w'(lanes * int'(w_addr) + k)] <= w_data.lane[k];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      rd_pipe[0] <= mem[r_addr];
      for (int i = 1; i < latency; i++) begin
        rd_pipe[i] <= rd_pipe[i-1];
      end
    end
  end

  assign r_data = rd_pipe[latency-1];  // Output after latency enabled edges

endmodule

// ==== src/cyclic_bram.sv ====
`include "cyclic_cfg.svh"

module cyclic_bram #(
  parameter int r_depth       = `CB_R_DEPTH,
  parameter int r_data_width  = `CB_R_DATA_WIDTH,
  parameter int w_data_width  = `CB_W_DATA_WIDTH,
  parameter int latency       = `CB_LATENCY,
  localparam int r_addr_w     = $clog2(r_depth),
  localparam int w_addr_w     = $clog2(r_depth * r_data_width / w_data_width)
)(
  input  logic                    clk,
  input  logic                    clken,
  input  logic                    arst_n,
  input  logic                    w_en,
  input  logic                    r_en,
  input  cyclic_pkg::cb_w_word_t  s_data,
  input  logic [r_addr_w-1:0]     r_addr_min,
  input  logic [r_addr_w-1:0]     r_addr_max,
  input  logic [w_addr_w-1:0]     w_addr_max,
  output logic [r_data_width-1:0] m_data,
  output logic                    m_valid
);

  logic [w_addr_w-1:0]             w_addr;
  logic [r_addr_w-1:0]             r_addr;
  logic [latency-1:0]              issued;     // Read-issue bits riding with the data
  logic [r_data_width-1:0]         bram_data;
  logic [$clog2(latency+2)-1:0]    pending;    // Reads issued but not yet matched by a pop

  // Write address wraps to 0 after the write maximum
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      w_addr <= '0;
    end else if (clken && w_en) begin
      w_addr <= (w_addr == w_addr_max) ? '0 : w_addr + 1'b1;
    end
  end

  // Read address replays the window between min and max
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      r_addr <= '0;
    end else if (clken && r_en) begin
      r_addr <= (r_addr == r_addr_max) ? r_addr_min : r_addr + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      issued <= '0;
    end else if (clken) begin
      issued <= (issued << 1) | latency'(r_en);
    end
  end

  // Grows only while priming, after that every request also pops
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pending <= '0;
    end else if (clken && r_en && !m_valid) begin
      pending <= pending + 1'b1;
    end
  end

  bram_sdp #(
    .r_depth      (r_depth),
    .r_data_width (r_data_width),
    .w_data_width (w_data_width),
    .latency      (latency)
  ) bram (
    .clk    (clk),
    .en     (clken),
    .we     (w_en),
    .w_addr (w_addr),
    .w_data (s_data),
    .r_addr (r_addr),
    .r_data (bram_data)
  );

  absorb_fifo #(
    .width (r_data_width),
    .depth (latency)
  ) queue (
    .clk       (clk),
    .arst_n    (arst_n),
    .en        (clken),
    .push      (issued[latency-1]),  // Data leaves the memory with its issue bit
    .push_data (bram_data),
    .pop       (r_en),
    .valid     (m_valid),
    .head      (m_data)
  );

  a_window_order: assert property (@(posedge clk) disable iff (!arst_n)
    r_addr_min <= r_addr_max);

  // Nothing requested yet means nothing may be shown
  a_valid_needs_read: assert property (@(posedge clk) disable iff (!arst_n)
    clken && r_en && (pending == '0) |-> !m_valid);

endmodule

// ==== src/cyclic_buffer.sv ====
`include "cyclic_cfg.svh"

module cyclic_buffer (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              clken,
  input  logic                              cfg_load,
  input  logic [cyclic_pkg::cb_r_addr_w-1:0] cfg_r_addr_min,
  input  logic [cyclic_pkg::cb_r_addr_w-1:0] cfg_r_addr_max,
  input  logic [cyclic_pkg::cb_w_addr_w-1:0] cfg_w_addr_max,
  input  logic                              w_en,
  input  logic [`CB_W_DATA_WIDTH-1:0]       s_data,
  input  logic                              r_en,
  output logic [`CB_R_DATA_WIDTH-1:0]       m_data,
  output logic                              m_valid
);

  import cyclic_pkg::*;

  logic [cb_r_addr_w-1:0] r_addr_min;
  logic [cb_r_addr_w-1:0] r_addr_max;
  logic [cb_w_addr_w-1:0] w_addr_max;
  cb_w_word_t             s_word;

  // Limits default to the full memory
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      r_addr_min <= '0;
      r_addr_max <= cb_r_addr_w'(`CB_R_DEPTH - 1);
      w_addr_max <= cb_w_addr_w'(cb_w_depth - 1);
    end else if (cfg_load) begin
      r_addr_min <= cfg_r_addr_min;
      r_addr_max <= cfg_r_addr_max;
      w_addr_max <= cfg_w_addr_max;
    end
  end

  assign s_word = cb_w_word_t'(s_data);

  cyclic_bram #(
    .r_depth      (`CB_R_DEPTH),
    .r_data_width (`CB_R_DATA_WIDTH),
    .w_data_width (`CB_W_DATA_WIDTH),
    .latency      (`CB_LATENCY)
  ) core (
    .clk        (clk),
    .clken      (clken),
    .arst_n     (arst_n),
    .w_en       (w_en),
    .r_en       (r_en),
    .s_data     (s_word),
    .r_addr_min (r_addr_min),
    .r_addr_max (r_addr_max),
    .w_addr_max (w_addr_max),
    .m_data     (m_data),
    .m_valid    (m_valid)
  );

endmodule

// ==== src/cyclic_pkg.sv ====
`include "cyclic_cfg.svh"

package cyclic_pkg;

  localparam int cb_lanes    = `CB_W_DATA_WIDTH / `CB_R_DATA_WIDTH;
  localparam int cb_w_depth  = `CB_R_DEPTH / cb_lanes;
  localparam int cb_r_addr_w = $clog2(`CB_R_DEPTH);
  localparam int cb_w_addr_w = $clog2(cb_w_depth);

  // One write word, seen whole or as read lanes with lane 0 in the low byte
  typedef union packed {
    logic [`CB_W_DATA_WIDTH-1:0]               raw;
    logic [cb_lanes-1:0][`CB_R_DATA_WIDTH-1:0] lane;
  } cb_w_word_t;

endpackage
